// File: common/fixed_pkg.sv
package fixed_pkg;

    //////////////////////////////
    // Sample and result widths
    //////////////////////////////

    // One sample word, Q2.13 signed
    localparam int DATA_W = 16;
    // Fraction bits of a sample
    localparam int FRAC_BITS = 13;

    // ln(4) in Q2.13
    // exp_x saturates from here up
    localparam int LN4_Q = 11357;
    // log2(e) scaled by 2^13
    localparam int LOG2E_Q = 11819;
    // Largest positive Q2.13 word
    localparam int EXP_SAT = 32767;

    // Fraction bits used to address the 2^f tables
    localparam int LUT_IDX_W = 6;

    // Input sample, Q2.13
    typedef logic signed [DATA_W-1:0] data_t;
    // Output probability, Q0.15 in the low 15 bits
    typedef logic [DATA_W-1:0] prob_t;

endpackage

// File: common/softmax_ctl_pkg.sv
package softmax_ctl_pkg;

    // Width of the controller state register
    localparam int STATE_W = 3;

    // Controller phases in order of use
    typedef enum logic [STATE_W-1:0] {
        // Waiting for the first sample
        idle       = 3'd0,
        // Filling the buffer, max tracking
        load       = 3'd1,
        // One exponential per cycle, sum builds up
        expo       = 3'd2,
        // Kick off one division
        norm_start = 3'd3,
        // Waiting on the divider
        norm_wait  = 3'd4,
        // One-cycle end of vector
        done       = 3'd5
    } ctl_state_t;

endpackage

// File: exp/mul_fast.sv
`timescale 1ns/1ps

module log2_scale #(
    parameter int D_W = 16
) (
    input  logic signed [D_W-1:0] x,
    output logic        [D_W:0]   uivi
);

    // Binary point of the product, same as the sample's
    localparam int FRAC_S = (D_W == 8) ? 5 : fixed_pkg::FRAC_BITS;

    // Full width signed product x * log2(e)
    logic signed [2*D_W-1:0] prod;

    if (D_W == 8) begin : g_w8
        // log2(e) in Q2.5
        assign prod = x * 8'sd46;
    end else begin : g_w16
        // log2(e) in Q2.13
        assign prod = x * $signed(D_W'(fixed_pkg::LOG2E_Q));
    end

    // Sign bit, then integer and fraction field of the product
    // top two integer bits dropped, range never reaches them
    assign uivi = {prod[2*D_W-1], prod[2*D_W-4:FRAC_S]};

endmodule

// File: exp/pow2_lut.sv
`timescale 1ns/1ps

module pow2_lut #(
    parameter int D_W = 16
) (
    input  logic [fixed_pkg::LUT_IDX_W-1:0] vi_idx,
    output logic [D_W-1:0]                  pos_val,
    output logic [D_W-1:0]                  neg_val
);

    // Narrow variant keeps 32 entries in Q2.5
    localparam int IDX_W     = (D_W == 8) ? 5 : fixed_pkg::LUT_IDX_W;
    // Weight of 1.0 in table words
    localparam int ONE_SHIFT = (D_W == 8) ? 5 : fixed_pkg::FRAC_BITS;
    localparam int DEPTH     = 1 << IDX_W;

    // round(2^(+-k/DEPTH) * 2^ONE_SHIFT)
    function automatic int pow2_entry(input int k, input bit neg);
        real e;
        real v;
        e = real'(k) / real'(DEPTH);
        if (neg) begin
            e = -e;
        end
        v = (2.0 ** e) * real'(1 << ONE_SHIFT);
        return $rtoi(v + 0.5);
    endfunction

    logic [D_W-1:0] pos_tab [DEPTH];
    logic [D_W-1:0] neg_tab [DEPTH];
    logic [IDX_W-1:0] idx;

    //////////////////////////////
    // Table fill at elaboration
    //////////////////////////////

    for (genvar k = 0; k < DEPTH; k++) begin : g_tab
        localparam int POS_E = pow2_entry(k, 1'b0);
        localparam int NEG_E = pow2_entry(k, 1'b1);
        // 2^(k/DEPTH), 1.0 up to just under 2.0
        assign pos_tab[k] = D_W'(POS_E);
        // 2^(-k/DEPTH), 0.5 up to 1.0
        assign neg_tab[k] = D_W'(NEG_E);
    end

    // Upper fraction bits only
    assign idx = vi_idx[fixed_pkg::LUT_IDX_W-1 -: IDX_W];

    // Both entries always out, exp_x picks by sign
    assign pos_val = pos_tab[idx];
    assign neg_val = neg_tab[idx];

endmodule

// File: exp/exp_x.sv
`timescale 1ns/1ps

module exp_x #(
    parameter int D_W = 16
) (
    input  fixed_pkg::data_t x,
    output logic [D_W-1:0]   exp_out
);

    // Fraction bits of the working word
    localparam int FRAC_S = (D_W == 8) ? 5 : fixed_pkg::FRAC_BITS;

    logic signed [D_W-1:0]           x_w;
    logic [D_W:0]                    uivi;
    logic                            uivi_msb;
    logic [D_W-1:0]                  uivi_ab;
    logic [2:0]                      ui;
    logic [FRAC_S-1:0]               vi;
    logic [fixed_pkg::LUT_IDX_W-1:0] vi_idx;
    logic [D_W-1:0]                  pos_val;
    logic [D_W-1:0]                  neg_val;
    logic                            x_sat;
    logic [D_W-1:0]                  sat_word;

    // Top D_W bits of the sample, Q2.5 in the narrow case
    assign x_w = x[fixed_pkg::DATA_W-1 -: D_W];

    // exp(x) = 2^(x*log2 e), split into 2^ui * 2^vi
    log2_scale #(
        .D_W (D_W)
    ) i_log2_scale (
        .x    (x_w),
        .uivi (uivi)
    );

    assign uivi_msb = uivi[D_W];
    // Magnitude of the scaled value
    assign uivi_ab  = uivi_msb ? (~uivi[D_W-1:0] + 1'b1) : uivi[D_W-1:0];
    // Integer part gives the shift
    assign ui       = uivi_ab[D_W-1 -: 3];
    assign vi       = uivi_ab[FRAC_S-1:0];

    //////////////////////////////
    // 8 bit variant
    //////////////////////////////
    if (D_W == 8) begin : g_w8
        // ln4 in Q2.5
        assign x_sat    = x_w >= 8'sd44;
        assign sat_word = 8'b0_11_11111;
        // Five fraction bits, padded up to the index width
        assign vi_idx   = {vi, 1'b0};
    //////////////////////////////
    // 16 bit variant
    //////////////////////////////
    end else begin : g_w16
        assign x_sat    = x_w >= fixed_pkg::LN4_Q;
        assign sat_word = D_W'(fixed_pkg::EXP_SAT);
        // top fraction bits only
        assign vi_idx   = vi[FRAC_S-1 -: fixed_pkg::LUT_IDX_W];
    end

    pow2_lut #(
        .D_W (D_W)
    ) i_pow2_lut (
        .vi_idx  (vi_idx),
        .pos_val (pos_val),
        .neg_val (neg_val)
    );

    always_comb begin
        if (x_sat) begin
            // Result would no longer fit Q2.x
            exp_out = sat_word;
        end else if (!uivi_msb) begin
            exp_out = pos_val << ui;
        end else begin
            // Negative exponent, divide by 2^ui
            exp_out = neg_val >> ui;
        end
    end

endmodule

// File: src/norm_div.sv
`timescale 1ns/1ps

module norm_div #(
    parameter int D_W   = 16,
    parameter int SUM_W = 19
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             div_start,
    input  logic [D_W-1:0]   div_num,
    input  logic [SUM_W-1:0] div_den,
    output logic             div_busy,
    output logic             div_valid,
    output fixed_pkg::prob_t div_q
);

    // One quotient bit per cycle, weight 2^15 first
    localparam int Q_W   = $bits(fixed_pkg::prob_t);
    localparam int CNT_W = $clog2(Q_W + 1);

    logic [SUM_W:0]   rem;
    logic [SUM_W-1:0] den_r;
    logic [Q_W-1:0]   quo;
    logic [CNT_W-1:0] step;
    logic [SUM_W:0]   rem_diff;
    logic             rem_ge;
    logic             last_step;

    // Trial subtraction
    assign rem_diff  = rem - {1'b0, den_r};
    assign rem_ge    = rem >= {1'b0, den_r};
    // All quotient bits in, result goes out next edge
    assign last_step = step == CNT_W'(Q_W);

    //////////////////////////////
    // Sequencing
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            div_busy  <= 1'b0;
            div_valid <= 1'b0;
            step      <= '0;
        end else begin
            div_valid <= 1'b0;
            if (div_start) begin
                div_busy <= 1'b1;
                step     <= '0;
            end else if (div_busy) begin
                if (last_step) begin
                    div_busy  <= 1'b0;
                    div_valid <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Remainder and quotient
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (div_start) begin
            // First compare is against num itself
            rem   <= {{(SUM_W + 1 - D_W){1'b0}}, div_num};
            den_r <= div_den;
            quo   <= '0;
        end else if (div_busy && !last_step) begin
            if (rem_ge) begin
                rem <= {rem_diff[SUM_W-1:0], 1'b0};
                quo <= {quo[Q_W-2:0], 1'b1};
            end else begin
                rem <= {rem[SUM_W-1:0], 1'b0};
                quo <= {quo[Q_W-2:0], 1'b0};
            end
        end else if (div_busy) begin
            // num equal to den gives 1.0, clamp to largest Q0.15
            div_q <= quo[Q_W-1] ? {1'b0, {(Q_W - 1){1'b1}}} : quo;
        end
    end

    // Controller must wait for the previous quotient
    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        div_start |-> !div_busy);

    // Sum of exponentials is never empty
    a_den_nonzero: assert property (@(posedge clk) disable iff (reset)
        div_start |-> div_den != '0);

endmodule

// File: src/softmax_ctrl.sv
`timescale 1ns/1ps

module softmax_ctrl #(
    parameter int D_W     = 16,
    parameter int VEC_LEN = 8,
    parameter int SUM_W   = 19
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  fixed_pkg::data_t in_data,
    output fixed_pkg::data_t exp_in,
    input  logic [D_W-1:0]   exp_out,
    output logic             div_start,
    output logic [D_W-1:0]   div_num,
    output logic [SUM_W-1:0] div_den,
    input  logic             div_busy,
    input  logic             div_valid,
    input  fixed_pkg::prob_t div_q,
    output logic             busy,
    output logic             out_valid,
    output fixed_pkg::prob_t out_data,
    output logic             done
);

    localparam int IDX_W = $clog2(VEC_LEN);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(VEC_LEN - 1);

    softmax_ctl_pkg::ctl_state_t state;

    fixed_pkg::data_t                buf_mem [VEC_LEN];
    fixed_pkg::data_t                max_r;
    logic [IDX_W-1:0]                idx;
    logic [SUM_W-1:0]                sum_r;
    logic                            last_idx;
    logic                            accept;
    logic [IDX_W-1:0]                wr_idx;
    logic signed [fixed_pkg::DATA_W:0] diff;

    assign last_idx = idx == LAST;

    // Samples taken while not busy, or while loading
    assign accept = in_valid && (state == softmax_ctl_pkg::idle ||
                                 state == softmax_ctl_pkg::done ||
                                 state == softmax_ctl_pkg::load);
    // First sample always lands in slot 0
    assign wr_idx = (state == softmax_ctl_pkg::load) ? idx : '0;

    //////////////////////////////
    // Exponential input
    //////////////////////////////

    // x minus max, one bit wider
    assign diff = {buf_mem[idx][fixed_pkg::DATA_W-1], buf_mem[idx]} -
                  {max_r[fixed_pkg::DATA_W-1], max_r};

    always_comb begin
        // Only the low side can overflow, x never exceeds max
        if (diff[fixed_pkg::DATA_W] && !diff[fixed_pkg::DATA_W-1]) begin
            exp_in = {1'b1, {(fixed_pkg::DATA_W - 1){1'b0}}};
        end else begin
            exp_in = diff[fixed_pkg::DATA_W-1:0];
        end
    end

    //////////////////////////////
    // Phase FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= softmax_ctl_pkg::idle;
            idx       <= '0;
            max_r     <= '0;
            sum_r     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            unique case (state)
                softmax_ctl_pkg::idle, softmax_ctl_pkg::done: begin
                    if (in_valid) begin
                        max_r <= in_data;
                        idx   <= IDX_W'(1);
                        state <= softmax_ctl_pkg::load;
                    end else begin
                        state <= softmax_ctl_pkg::idle;
                    end
                end
                softmax_ctl_pkg::load: begin
                    if (in_valid) begin
                        if (in_data > max_r) begin
                            max_r <= in_data;
                        end
                        if (last_idx) begin
                            idx   <= '0;
                            sum_r <= '0;
                            state <= softmax_ctl_pkg::expo;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                softmax_ctl_pkg::expo: begin
                    // One element per cycle
                    sum_r <= sum_r + SUM_W'(exp_out);
                    if (last_idx) begin
                        idx   <= '0;
                        state <= softmax_ctl_pkg::norm_start;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                softmax_ctl_pkg::norm_start: begin
                    if (!div_busy) begin
                        state <= softmax_ctl_pkg::norm_wait;
                    end
                end
                softmax_ctl_pkg::norm_wait: begin
                    if (div_valid) begin
                        out_valid <= 1'b1;
                        if (!last_idx) begin
                            idx   <= idx + 1'b1;
                            state <= softmax_ctl_pkg::norm_start;
                        end
                    end else if (out_valid && last_idx) begin
                        // last probability is out, close the vector
                        state <= softmax_ctl_pkg::done;
                    end
                end
                default: state <= softmax_ctl_pkg::idle;
            endcase
        end
    end

    // Buffer holds samples first, then their exponentials
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_mem[wr_idx] <= in_data;
        end else if (state == softmax_ctl_pkg::expo) begin
            buf_mem[idx] <= fixed_pkg::data_t'(exp_out);
        end
    end

    // Quotient shows up one cycle after the divider flags it
    always_ff @(posedge clk) begin
        if (div_valid) begin
            out_data <= div_q;
        end
    end

    assign div_start = (state == softmax_ctl_pkg::norm_start) && !div_busy;
    assign div_num   = buf_mem[idx][D_W-1:0];
    assign div_den   = sum_r;

    assign busy = (state != softmax_ctl_pkg::idle) && (state != softmax_ctl_pkg::done);
    assign done = state == softmax_ctl_pkg::done;

    // Outputs only in the division pass, divider already idle
    a_out_in_norm: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (state == softmax_ctl_pkg::norm_start ||
                       state == softmax_ctl_pkg::norm_wait) && !div_busy);

    // End of vector never overlaps the last output
    a_done_alone: assert property (@(posedge clk) disable iff (reset)
        !(done && out_valid));

endmodule

// File: src/softmax_unit.sv
`timescale 1ns/1ps

module softmax_unit #(
    parameter int D_W     = 16,
    parameter int VEC_LEN = 8,
    parameter int SUM_W   = D_W + $clog2(VEC_LEN)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  fixed_pkg::data_t in_data,
    output logic             busy,
    output logic             out_valid,
    output fixed_pkg::prob_t out_data,
    output logic             done
);

    // Controller to exponential unit
    fixed_pkg::data_t exp_in;
    logic [D_W-1:0]   exp_out;

    // Controller to divider
    logic             div_start;
    logic [D_W-1:0]   div_num;
    logic [SUM_W-1:0] div_den;
    logic             div_busy;
    logic             div_valid;
    fixed_pkg::prob_t div_q;

    softmax_ctrl #(
        .D_W     (D_W),
        .VEC_LEN (VEC_LEN),
        .SUM_W   (SUM_W)
    ) i_softmax_ctrl (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .exp_in    (exp_in),
        .exp_out   (exp_out),
        .div_start (div_start),
        .div_num   (div_num),
        .div_den   (div_den),
        .div_busy  (div_busy),
        .div_valid (div_valid),
        .div_q     (div_q),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data),
        .done      (done)
    );

    // Purely combinational, result used in the same cycle
    exp_x #(
        .D_W (D_W)
    ) i_exp_x (
        .x       (exp_in),
        .exp_out (exp_out)
    );

    norm_div #(
        .D_W   (D_W),
        .SUM_W (SUM_W)
    ) i_norm_div (
        .clk       (clk),
        .reset     (reset),
        .div_start (div_start),
        .div_num   (div_num),
        .div_den   (div_den),
        .div_busy  (div_busy),
        .div_valid (div_valid),
        .div_q     (div_q)
    );

endmodule

// File: tests/softmax_model.svh
`ifndef SOFTMAX_MODEL_SVH
`define SOFTMAX_MODEL_SVH

//////////////////////////////
// Reference arithmetic
//////////////////////////////

// Table entry 2^(+-k/64) in Q2.13, rounded to nearest
function automatic int pow2_table(input int k, input bit neg);
    real e;
    e = real'(k) / real'(1 << fixed_pkg::LUT_IDX_W);
    if (neg) begin
        e = -e;
    end
    return $rtoi((2.0 ** e) * real'(1 << fixed_pkg::FRAC_BITS) + 0.5);
endfunction

// exp(x) for one Q2.13 sample, wide variant only
function automatic int exp_fixed(input int x);
    longint prod;
    longint sh;
    int     field;
    int     mag;
    int     ui;
    int     idx;
    bit     neg;
    if (x >= fixed_pkg::LN4_Q) begin
        return fixed_pkg::EXP_SAT;
    end
    // x * log2(e), point at bit 13
    prod = longint'(x) * fixed_pkg::LOG2E_Q;
    neg  = prod < 0;
    sh   = prod >>> fixed_pkg::FRAC_BITS;
    // 16 bit integer plus fraction field, two's complement
    field = int'(sh & 64'hFFFF);
    mag   = neg ? ((65536 - field) & 'hFFFF) : field;
    // Top 3 bits are the shift
    ui  = mag >> fixed_pkg::FRAC_BITS;
    // Upper fraction bits pick the entry
    idx = (mag & ((1 << fixed_pkg::FRAC_BITS) - 1)) >>
          (fixed_pkg::FRAC_BITS - fixed_pkg::LUT_IDX_W);
    if (neg) begin
        return pow2_table(idx, 1'b1) >> ui;
    end
    return (pow2_table(idx, 1'b0) << ui) & 'hFFFF;
endfunction

// x minus max, clipped at the most negative word
function automatic int sat_diff(input int x, input int m);
    int d;
    d = x - m;
    if (d < -32768) begin
        d = -32768;
    end
    return d;
endfunction

// floor(num * 2^15 / den), clamped to the top Q0.15 value
function automatic int div_prob(input int num, input int den);
    longint q;
    q = (longint'(num) << 15) / den;
    if (q > 32767) begin
        q = 32767;
    end
    return int'(q);
endfunction

`endif

// File: tests/tb_softmax.sv
`timescale 1ns/1ps

module tb_softmax;

    localparam int D_W     = 16;
    localparam int VEC_LEN = 8;
    localparam int NUM_VEC = 20;
    // Budget per vector, with room for reset
    localparam int TIMEOUT_CYC = NUM_VEC * (VEC_LEN * 20 + 40) + 200;
    // Equal inputs, every exp is 1.0
    localparam int EQUAL_PROB = (8192 * 32768) / (VEC_LEN * 8192);

    `include "softmax_model.svh"

    logic             clk;
    logic             reset;
    logic             in_valid;
    fixed_pkg::data_t in_data;
    logic             busy;
    logic             out_valid;
    fixed_pkg::prob_t out_data;
    logic             done;

    int seed = 81491;
    int errors = 0;
    int checks = 0;

    // Samples of the vector being sent
    int vec_data [VEC_LEN];
    // Expected probabilities, oldest first
    int exp_q [$];

    // Monitor bookkeeping
    int   pulse_cnt = 0;
    int   vec_seen = 0;
    logic out_valid_d = 1'b0;
    logic done_d = 1'b0;
    logic busy_d = 1'b0;

    softmax_unit #(
        .D_W     (D_W),
        .VEC_LEN (VEC_LEN)
    ) i_softmax_unit (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data),
        .done      (done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_value(input string name, input int actual, input int expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, actual, expected);
        end
    endtask

    // Model result for vec_data into the queue
    task automatic push_expected();
        int m;
        int sum;
        int i;
        int e [VEC_LEN];
        m = vec_data[0];
        for (i = 1; i < VEC_LEN; i++) begin
            if (vec_data[i] > m) begin
                m = vec_data[i];
            end
        end
        sum = 0;
        for (i = 0; i < VEC_LEN; i++) begin
            e[i] = exp_fixed(sat_diff(vec_data[i], m));
            sum += e[i];
        end
        for (i = 0; i < VEC_LEN; i++) begin
            exp_q.push_back(div_prob(e[i], sum));
        end
    endtask

    // Load one vector, then strobe junk while busy until done
    task automatic send_vector(input int extra_strobes);
        int i;
        int sent;
        for (i = 0; i < VEC_LEN; i++) begin
            // Occasional idle cycle inside the load phase
            if (i > 0 && ($random(seed) & 3) == 0) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = fixed_pkg::data_t'(vec_data[i]);
        end
        @(negedge clk);
        in_valid = 1'b0;
        sent = 0;
        while (!done) begin
            if (busy && sent < extra_strobes && ($random(seed) & 1)) begin
                // Should be dropped by the controller
                in_valid = 1'b1;
                in_data  = fixed_pkg::data_t'($random(seed));
                sent++;
            end else begin
                in_valid = 1'b0;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    //////////////////////////////
    // Output monitor
    //////////////////////////////
    always @(negedge clk) begin
        if (out_valid && done) begin
            errors++;
            $display("ERROR at %0t: out_valid and done high in the same cycle", $time);
        end
        if (done && done_d) begin
            errors++;
            $display("ERROR at %0t: done stayed high for more than one cycle", $time);
        end
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR at %0t: out_valid with no expected value pending", $time);
            end else begin
                check_value("out_data", out_data, exp_q.pop_front());
            end
            pulse_cnt++;
        end
        if (done) begin
            check_value("out_valid pulses", pulse_cnt, VEC_LEN);
            // Last output right before done, busy drops with done
            check_value("out_valid before done", out_valid_d, 1);
            check_value("busy at done", busy, 0);
            check_value("busy before done", busy_d, 1);
            pulse_cnt = 0;
            vec_seen++;
        end
        out_valid_d = out_valid;
        done_d      = done;
        busy_d      = busy;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin : stimulus
        int v;
        int i;
        int base;
        int extras;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Quiet outputs straight out of reset
        check_value("busy after reset", busy, 0);
        check_value("out_valid after reset", out_valid, 0);
        check_value("done after reset", done, 0);

        for (v = 0; v < NUM_VEC; v++) begin
            extras = (v % 4 == 3) ? 6 : 0;
            if (v == 0) begin
                // All equal
                base = int'(fixed_pkg::data_t'($random(seed)));
                for (i = 0; i < VEC_LEN; i++) begin
                    vec_data[i] = base;
                end
            end else if (v == 1) begin
                // Range near 8, differences saturate
                vec_data[0] = 32767;
                for (i = 1; i < VEC_LEN; i++) begin
                    vec_data[i] = -32768 + ($random(seed) & 8191);
                end
            end else if (v % 5 == 2) begin
                // Within +-0.5, spread out exponentials
                for (i = 0; i < VEC_LEN; i++) begin
                    vec_data[i] = $random(seed) % 4096;
                end
            end else begin
                for (i = 0; i < VEC_LEN; i++) begin
                    vec_data[i] = int'(fixed_pkg::data_t'($random(seed)));
                end
            end
            if (v == 0) begin
                for (i = 0; i < VEC_LEN; i++) begin
                    exp_q.push_back(EQUAL_PROB);
                end
            end else begin
                push_expected();
            end
            send_vector(extras);
        end

        repeat (5) @(negedge clk);
        check_value("vectors completed", vec_seen, NUM_VEC);
        check_value("outputs still expected", exp_q.size(), 0);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Hard stop if the DUT stalls
    initial begin : watchdog
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tests
common/fixed_pkg.sv
common/softmax_ctl_pkg.sv
exp/mul_fast.sv
exp/pow2_lut.sv
exp/exp_x.sv
src/norm_div.sv
src/softmax_ctrl.sv
src/softmax_unit.sv
tests/tb_softmax.sv

// File: Makefile
# Verilator build and run of the softmax testbench

.PHONY: run build clean

run: obj_dir/Vtb_softmax
	./obj_dir/Vtb_softmax | tee sim.log
	grep -qxF '=== PASS ===' sim.log

build: obj_dir/Vtb_softmax

# Rebuilt only when a source, the header or the file list changes
obj_dir/Vtb_softmax: vlog.f $(shell grep -v '^+' vlog.f) tests/softmax_model.svh
	verilator --binary --timing --assert -Wno-fatal --top-module tb_softmax -f vlog.f

clean:
	rm -rf obj_dir sim.log
